// ==== src/execPkg.sv ====
package execPkg;

    localparam int WORD_W = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0] wordT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;
    typedef logic [15:0] imm16T;
    typedef logic [4:0] shamtT;
    typedef logic [1:0] tnewT;

    // Countdown wide enough for the longest multiply/divide latency
    typedef logic [3:0] mdCountT;

    localparam mdCountT MULT_CYCLES = 4'd5;
    localparam mdCountT DIV_CYCLES = 4'd10;

    // NOP must stay at zero, a cleared pipeline register reads as nop
    typedef enum logic [5:0] {
        NOP,
        ADD, ADDU, SUB, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI,
        LW, SW,
        MULT, MULTU, DIV, DIVU,
        MFHI, MFLO, MTHI, MTLO
    } instrT;

    typedef enum logic [3:0] {
        ALU_ZERO,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOpT;

    typedef enum logic [3:0] {
        MD_NONE,
        MD_MULT,
        MD_MULTU,
        MD_DIV,
        MD_DIVU,
        MD_MTHI,
        MD_MTLO,
        MD_MFHI,
        MD_MFLO
    } mdOpT;

    // Where the stage result written back to the register file comes from
    typedef enum logic [1:0] {
        RES_DEST,
        RES_ALU,
        RES_MD
    } resSelT;

endpackage

// ==== src/execCtrlIf.sv ====
`timescale 1ns/1ps

interface execCtrlIf;
    import execPkg::*;

    aluOpT aluOp;
    logic immSigned;
    logic useImm;
    logic useShamt;
    mdOpT mdOp;
    resSelT resultSel;

    modport decoder (
        output aluOp,
        output immSigned,
        output useImm,
        output useShamt,
        output mdOp,
        output resultSel
    );

    modport alu (
        input aluOp,
        input immSigned,
        input useImm,
        input useShamt
    );

    modport mulDiv (
        input mdOp
    );

    // Stage top needs mdOp to spot mfhi/mflo for memResult
    modport stage (
        input resultSel,
        input mdOp
    );

endinterface

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input execPkg::instrT instr,
    execCtrlIf.decoder ctrl
);
    import execPkg::*;

    always_comb begin
        // Defaults describe an instruction that passes destData through
        ctrl.aluOp = ALU_ZERO;
        ctrl.immSigned = 1'b1;
        ctrl.useImm = 1'b0;
        ctrl.useShamt = 1'b0;
        ctrl.mdOp = MD_NONE;
        ctrl.resultSel = RES_DEST;

        case (instr)
            ADD, ADDU: begin
                ctrl.aluOp = ALU_ADD;
                ctrl.resultSel = RES_ALU;
            end
            SUB, SUBU: begin
                ctrl.aluOp = ALU_SUB;
                ctrl.resultSel = RES_ALU;
            end
            AND, OR, XOR, NOR: begin
                ctrl.aluOp = (instr == AND) ? ALU_AND :
                             (instr == OR) ? ALU_OR :
                             (instr == XOR) ? ALU_XOR : ALU_NOR;
                ctrl.resultSel = RES_ALU;
            end
            SLT, SLTU: begin
                ctrl.aluOp = (instr == SLT) ? ALU_SLT : ALU_SLTU;
                ctrl.resultSel = RES_ALU;
            end
            // Fixed shifts take shamt as the A operand
            SLL, SRL, SRA: begin
                ctrl.aluOp = (instr == SLL) ? ALU_SLL :
                             (instr == SRL) ? ALU_SRL : ALU_SRA;
                ctrl.useShamt = 1'b1;
                ctrl.resultSel = RES_ALU;
            end
            SLLV, SRLV, SRAV: begin
                ctrl.aluOp = (instr == SLLV) ? ALU_SLL :
                             (instr == SRLV) ? ALU_SRL : ALU_SRA;
                ctrl.resultSel = RES_ALU;
            end
            ADDI, ADDIU, SLTI, SLTIU: begin
                ctrl.aluOp = (instr == SLTI) ? ALU_SLT :
                             (instr == SLTIU) ? ALU_SLTU : ALU_ADD;
                ctrl.useImm = 1'b1;
                ctrl.resultSel = RES_ALU;
            end
            // Logical immediates and lui are zero extended
            ANDI, ORI, XORI, LUI: begin
                ctrl.aluOp = (instr == ANDI) ? ALU_AND :
                             (instr == ORI) ? ALU_OR :
                             (instr == XORI) ? ALU_XOR : ALU_LUI;
                ctrl.immSigned = 1'b0;
                ctrl.useImm = 1'b1;
                ctrl.resultSel = RES_ALU;
            end
            // Address calculation only, the load data arrives later
            LW, SW: begin
                ctrl.aluOp = ALU_ADD;
                ctrl.useImm = 1'b1;
            end
            MULT: ctrl.mdOp = MD_MULT;
            MULTU: ctrl.mdOp = MD_MULTU;
            DIV: ctrl.mdOp = MD_DIV;
            DIVU: ctrl.mdOp = MD_DIVU;
            MTHI: ctrl.mdOp = MD_MTHI;
            MTLO: ctrl.mdOp = MD_MTLO;
            MFHI, MFLO: begin
                ctrl.mdOp = (instr == MFHI) ? MD_MFHI : MD_MFLO;
                ctrl.resultSel = RES_MD;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/operandForward.sv ====
`timescale 1ns/1ps

module operandForward (
    input execPkg::regAddrT rsAddr,
    input execPkg::regAddrT rtAddr,
    input execPkg::wordT rsData,
    input execPkg::wordT rtData,
    input execPkg::regAddrT memRegAddr,
    input execPkg::wordT memRegData,
    input execPkg::regAddrT wbRegAddr,
    input execPkg::wordT wbRegData,
    output execPkg::wordT rsValue,
    output execPkg::wordT rtValue
);
    import execPkg::*;

    // Newest producer wins, register 0 is hardwired and never bypassed
    function automatic wordT bypass(
        input regAddrT srcAddr,
        input wordT fileData,
        input regAddrT memAddr,
        input wordT memData,
        input regAddrT wbAddr,
        input wordT wbData
    );
        wordT value;
        if (memAddr != '0 && memAddr == srcAddr) begin
            value = memData;
        end else if (wbAddr != '0 && wbAddr == srcAddr) begin
            value = wbData;
        end else begin
            value = fileData;
        end
        return value;
    endfunction

    always_comb begin
        rsValue = bypass(rsAddr, rsData, memRegAddr, memRegData,
                         wbRegAddr, wbRegData);
        rtValue = bypass(rtAddr, rtData, memRegAddr, memRegData,
                         wbRegAddr, wbRegData);
    end

endmodule

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
    execCtrlIf.alu ctrl,
    input execPkg::wordT rsValue,
    input execPkg::wordT rtValue,
    input execPkg::imm16T imm16,
    input execPkg::shamtT shamt,
    output execPkg::wordT result
);
    import execPkg::*;

    wordT extImm;
    wordT srcA;
    wordT srcB;
    shamtT shiftBy;

    // Immediate extension
    always_comb begin
        if (ctrl.immSigned) begin
            extImm = {{16{imm16[15]}}, imm16};
        end else begin
            extImm = {16'b0, imm16};
        end
    end

    // Operand selection
    always_comb begin
        srcA = ctrl.useShamt ? {27'b0, shamt} : rsValue;
        srcB = ctrl.useImm ? extImm : rtValue;
    end

    // Shifts move B by the low five bits of A
    assign shiftBy = srcA[4:0];

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: begin
                result = srcA + srcB;
            end
            ALU_SUB: begin
                result = srcA - srcB;
            end
            ALU_AND: begin
                result = srcA & srcB;
            end
            ALU_OR: begin
                result = srcA | srcB;
            end
            ALU_XOR: begin
                result = srcA ^ srcB;
            end
            ALU_NOR: begin
                result = ~(srcA | srcB);
            end
            ALU_SLT: begin
                result = {31'b0, $signed(srcA) < $signed(srcB)};
            end
            ALU_SLTU: begin
                result = {31'b0, srcA < srcB};
            end
            ALU_SLL: begin
                result = srcB << shiftBy;
            end
            ALU_SRL: begin
                result = srcB >> shiftBy;
            end
            ALU_SRA: begin
                result = $signed(srcB) >>> shiftBy;
            end
            // Immediate goes to the upper half
            ALU_LUI: begin
                result = {srcB[15:0], 16'b0};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== src/mulDivUnit.sv ====
`timescale 1ns/1ps

module mulDivUnit (
    input logic clk,
    input logic reset,
    input logic stall,
    execCtrlIf.mulDiv ctrl,
    input execPkg::wordT rsValue,
    input execPkg::wordT rtValue,
    output logic busy,
    output execPkg::wordT hiLoValue
);
    import execPkg::*;

    wordT hi;
    wordT lo;
    mdCountT countdown;
    logic idle;
    logic isSigned;

    logic signed [63:0] extRs;
    logic signed [63:0] extRt;
    logic signed [63:0] divisor;
    logic signed [63:0] product;
    logic signed [63:0] quotient;
    logic signed [63:0] remainder;

    assign idle = (countdown == '0);

    // Hazard unit only cares while a mult/div class op is waiting
    assign busy = !idle && (ctrl.mdOp != MD_NONE);

    assign hiLoValue = (ctrl.mdOp == MD_MFHI) ? hi : lo;

    assign isSigned = (ctrl.mdOp == MD_MULT) || (ctrl.mdOp == MD_DIV);

    // 64-bit signed arithmetic covers both signed and unsigned forms
    always_comb begin
        if (isSigned) begin
            extRs = {{32{rsValue[31]}}, rsValue};
            extRt = {{32{rtValue[31]}}, rtValue};
        end else begin
            extRs = {32'b0, rsValue};
            extRt = {32'b0, rtValue};
        end
        divisor = (rtValue == '0) ? 64'sd1 : extRt;
        product = extRs * extRt;
        quotient = extRs / divisor;
        remainder = extRs % divisor;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
            countdown <= '0;
        end else if (!idle) begin
            countdown <= countdown - mdCountT'(1);
        end else if (!stall) begin
            case (ctrl.mdOp)
                MD_MULT, MD_MULTU: begin
                    countdown <= MULT_CYCLES;
                    hi <= product[63:32];
                    lo <= product[31:0];
                end
                MD_DIV, MD_DIVU: begin
                    countdown <= DIV_CYCLES;
                    // Zero divisor keeps the old HI/LO
                    if (rtValue != '0) begin
                        hi <= remainder[31:0];
                        lo <= quotient[31:0];
                    end
                end
                MD_MTHI: begin
                    hi <= rsValue;
                end
                MD_MTLO: begin
                    lo <= rsValue;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input execPkg::instrT instr,
    input execPkg::wordT pc,
    input execPkg::wordT rsData,
    input execPkg::wordT rtData,
    input execPkg::imm16T imm16,
    input execPkg::shamtT shamt,
    input execPkg::regAddrT rsAddr,
    input execPkg::regAddrT rtAddr,
    input execPkg::regAddrT destAddr,
    input execPkg::wordT destData,
    input execPkg::tnewT tnew,
    input execPkg::regAddrT memRegAddr,
    input execPkg::wordT memRegData,
    input execPkg::regAddrT wbRegAddr,
    input execPkg::wordT wbRegData,
    output execPkg::instrT memInstr,
    output execPkg::wordT memPc,
    output execPkg::wordT memResult,
    output execPkg::wordT memStoreData,
    output execPkg::regAddrT memRtAddr,
    output execPkg::regAddrT memDestAddr,
    output execPkg::wordT memDestData,
    output execPkg::tnewT memTnew,
    output logic mdBusy
);
    import execPkg::*;

    execCtrlIf ctrlBus ();

    wordT rsValue;
    wordT rtValue;
    wordT aluResult;
    wordT hiLoValue;
    wordT exResult;
    wordT exDestData;
    tnewT nextTnew;

    instrDecoder decoder0 (
        .instr(instr),
        .ctrl(ctrlBus.decoder)
    );

    operandForward forward0 (
        .rsAddr(rsAddr),
        .rtAddr(rtAddr),
        .rsData(rsData),
        .rtData(rtData),
        .memRegAddr(memRegAddr),
        .memRegData(memRegData),
        .wbRegAddr(wbRegAddr),
        .wbRegData(wbRegData),
        .rsValue(rsValue),
        .rtValue(rtValue)
    );

    aluUnit alu0 (
        .ctrl(ctrlBus.alu),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .imm16(imm16),
        .shamt(shamt),
        .result(aluResult)
    );

    mulDivUnit mulDiv0 (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .ctrl(ctrlBus.mulDiv),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .busy(mdBusy),
        .hiLoValue(hiLoValue)
    );

    // mfhi/mflo report HI/LO as their result, everything else the ALU
    assign exResult = (ctrlBus.mdOp == MD_MFHI || ctrlBus.mdOp == MD_MFLO) ?
                      hiLoValue : aluResult;

    always_comb begin
        case (ctrlBus.resultSel)
            RES_ALU: exDestData = aluResult;
            RES_MD: exDestData = hiLoValue;
            default: exDestData = destData;
        endcase
    end

    // One stage closer to ready, saturating at zero
    assign nextTnew = (tnew != '0) ? tnew - tnewT'(1) : '0;

    // EX/MEM register, flush beats stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            memInstr <= NOP;
            memPc <= '0;
            memResult <= '0;
            memStoreData <= '0;
            memRtAddr <= '0;
            memDestAddr <= '0;
            memDestData <= '0;
            memTnew <= '0;
        end else if (!stall) begin
            memInstr <= instr;
            memPc <= pc;
            memResult <= exResult;
            memStoreData <= rtValue;
            memRtAddr <= rtAddr;
            memDestAddr <= destAddr;
            memDestData <= exDestData;
            memTnew <= nextTnew;
        end
    end

endmodule

// ==== dv/executeStage_properties.sv ====
`timescale 1ns/1ps

module executeStage_properties (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input execPkg::instrT instr,
    input execPkg::instrT memInstr,
    input execPkg::wordT memResult,
    input execPkg::wordT memStoreData,
    input execPkg::wordT memDestData,
    input execPkg::tnewT memTnew,
    input logic mdBusy
);
    import execPkg::*;

    // Everything cleared and the unit idle one cycle after reset
    resetClears: assert property (@(posedge clk)
        reset |=> (memInstr == NOP && memResult == '0 && memDestData == '0
                   && memTnew == '0 && !mdBusy))
        else $error("outputs not cleared after reset");

    // Flush has priority even with stall high
    flushWinsOverStall: assert property (@(posedge clk)
        flush |=> (memInstr == NOP && memResult == '0 && memStoreData == '0
                   && memDestData == '0 && memTnew == '0))
        else $error("flush did not load a nop into the EX/MEM register");

    stallHolds: assert property (@(posedge clk) disable iff (reset)
        (stall && !flush) |=> ($stable(memInstr) && $stable(memResult)
                               && $stable(memStoreData) && $stable(memDestData)))
        else $error("EX/MEM register changed under stall");

    // A multiply or divide accepted at an edge makes the next mult/div class op wait
    busyAfterStart: assert property (@(posedge clk) disable iff (reset)
        ($past(!reset && !stall && !mdBusy && instr >= MULT && instr <= DIVU)
         && instr >= MULT && instr <= MTLO) |-> mdBusy)
        else $error("busy not raised right after a multiply/divide started");

endmodule

// ==== dv/executeStage_tb.sv ====
`timescale 1ns/1ps

module executeStage_tb;
    import execPkg::*;

    // Five tests of at most 400 cycles each, plus margin
    localparam int MAX_CYCLES = 3000;

    logic clk, reset, stall, flush, mdBusy;
    instrT instr, memInstr;
    wordT pc, rsData, rtData, destData, memRegData, wbRegData;
    wordT memPc, memResult, memStoreData, memDestData;
    imm16T imm16;
    shamtT shamt;
    regAddrT rsAddr, rtAddr, destAddr, memRegAddr, wbRegAddr, memRtAddr, memDestAddr;
    tnewT tnew, memTnew;

    // Reference model state and predicted EX/MEM contents
    wordT refHi, refLo, rsF, rtF;
    wordT expPc, expResult, expStore, expDestData;
    instrT expInstr;
    regAddrT expRt, expDest;
    tnewT expTnew;
    int refCount;
    logic signed [63:0] sa, sb;
    integer seed = 56;
    int cycles = 0;
    logic reported = 1'b0;
    string testName = "reset";

    executeStage dut0 (.*);

    bind executeStage executeStage_properties props0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Mix of edge values and random words for mult/div operands
    function automatic wordT corner();
        case (pick(6))
            0: return '0;
            1: return 32'd1;
            2: return '1;
            3: return 32'h8000_0000;
            4: return 32'h7fff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    // Memory stage first, then writeback, never register 0
    function automatic wordT forwarded(input regAddrT src, input wordT fileData);
        if (src == '0) begin
            return fileData;
        end
        return (src == memRegAddr) ? memRegData : (src == wbRegAddr) ? wbRegData : fileData;
    endfunction

    function automatic wordT aluExpected(input instrT op, input wordT rs, input wordT rt);
        wordT se;
        wordT ze;
        se = {{16{imm16[15]}}, imm16};
        ze = {16'h0, imm16};
        case (op)
            ADD, ADDU: return rs + rt;
            SUB, SUBU: return rs - rt;
            AND: return rs & rt;
            OR: return rs | rt;
            XOR: return rs ^ rt;
            NOR: return ~(rs | rt);
            SLT: return {31'b0, $signed(rs) < $signed(rt)};
            SLTU: return {31'b0, rs < rt};
            SLL: return rt << shamt;
            SRL: return rt >> shamt;
            SRA: return $signed(rt) >>> shamt;
            SLLV: return rt << rs[4:0];
            SRLV: return rt >> rs[4:0];
            SRAV: return $signed(rt) >>> rs[4:0];
            ADDI, ADDIU, LW, SW: return rs + se;
            ANDI: return rs & ze;
            ORI: return rs | ze;
            XORI: return rs ^ ze;
            SLTI: return {31'b0, $signed(rs) < $signed(se)};
            SLTIU: return {31'b0, rs < se};
            LUI: return {imm16, 16'h0};
            default: return '0;
        endcase
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic randomFields(input int addrMod);
        pc = $random(seed);
        rsData = $random(seed);
        rtData = $random(seed);
        imm16 = 16'($random(seed));
        shamt = 5'(pick(32));
        rsAddr = 5'(pick(addrMod));
        rtAddr = 5'(pick(addrMod));
        destAddr = 5'(pick(32));
        destData = $random(seed);
        tnew = 2'(pick(4));
        memRegAddr = 5'(pick(addrMod));
        memRegData = $random(seed);
        wbRegAddr = 5'(pick(addrMod));
        wbRegData = $random(seed);
    endtask

    task automatic expectEqual(input string what, input logic [31:0] expV,
                               input logic [31:0] actV);
        assert (actV === expV) else begin
            reported = 1'b1;
            $display("** Error %s %s: expected %h actual %h", testName, what, expV, actV);
            $display("Test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // Acts as the hazard unit while the multiply/divide unit is busy
    task automatic holdWhileBusy();
        #1;
        while (mdBusy) begin
            stall = 1'b1;
            nextCycle();
            #1;
        end
        stall = 1'b0;
    endtask

    // Reference model, inputs are stable at the rising edge
    always @(posedge clk) begin
        rsF = forwarded(rsAddr, rsData);
        rtF = forwarded(rtAddr, rtData);
        if (reset || flush) begin
            expInstr = NOP;
            expPc = '0;
            expResult = '0;
            expStore = '0;
            expDestData = '0;
            expRt = '0;
            expDest = '0;
            expTnew = '0;
        end else if (!stall) begin
            expInstr = instr;
            expPc = pc;
            if (instr == MFHI || instr == MFLO) begin
                expResult = (instr == MFHI) ? refHi : refLo;
            end else begin
                expResult = aluExpected(instr, rsF, rtF);
            end
            expStore = rtF;
            expRt = rtAddr;
            expDest = destAddr;
            // ALU class and HI/LO moves produce a value, the rest pass destData on
            if ((instr >= ADD && instr <= LUI) || instr == MFHI || instr == MFLO) begin
                expDestData = expResult;
            end else begin
                expDestData = destData;
            end
            expTnew = (tnew == '0) ? '0 : tnew - 2'd1;
        end
        if (reset) begin
            refHi = '0;
            refLo = '0;
            refCount = 0;
        end else if (refCount != 0) begin
            refCount = refCount - 1;
        end else if (!stall) begin
            sa = (instr == MULT || instr == DIV) ? {{32{rsF[31]}}, rsF} : {32'b0, rsF};
            sb = (instr == MULT || instr == DIV) ? {{32{rtF[31]}}, rtF} : {32'b0, rtF};
            case (instr)
                MULT, MULTU: begin
                    {refHi, refLo} = sa * sb;
                    refCount = MULT_CYCLES;
                end
                DIV, DIVU: begin
                    if (rtF != '0) begin
                        refHi = 32'(sa % sb);
                        refLo = 32'(sa / sb);
                    end
                    refCount = DIV_CYCLES;
                end
                MTHI: refHi = rsF;
                MTLO: refLo = rsF;
                default: ;
            endcase
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            reported = 1'b1;
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // Registered outputs settle well before the falling edge
    always @(negedge clk) begin
        if (cycles > 0) begin
            expectEqual("memInstr", 32'(expInstr), 32'(memInstr));
            expectEqual("memPc", expPc, memPc);
            expectEqual("memResult", expResult, memResult);
            expectEqual("memStoreData", expStore, memStoreData);
            expectEqual("memRtAddr", 32'(expRt), 32'(memRtAddr));
            expectEqual("memDestAddr", 32'(expDest), 32'(memDestAddr));
            expectEqual("memDestData", expDestData, memDestData);
            expectEqual("memTnew", 32'(expTnew), 32'(memTnew));
            expectEqual("mdBusy", 32'(refCount != 0 && instr >= MULT && instr <= MTLO),
                        32'(mdBusy));
        end
    end

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        instr = NOP;
        randomFields(32);
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        testName = "alu";
        repeat (300) begin
            randomFields(32);
            instr = instrT'(1 + pick(26));
            nextCycle();
        end

        // Small register range so bypass sources collide often
        testName = "forward";
        repeat (200) begin
            randomFields(4);
            instr = instrT'(1 + pick(26));
            nextCycle();
        end

        testName = "muldiv";
        repeat (24) begin
            randomFields(32);
            rsData = corner();
            rtData = corner();
            instr = instrT'(MULT + pick(4));
            nextCycle();
            instr = MFHI;
            holdWhileBusy();
            nextCycle();
            instr = MFLO;
            nextCycle();
        end
        instr = MTHI;
        rsData = $random(seed);
        nextCycle();
        instr = MFHI;
        nextCycle();
        instr = MTLO;
        rsData = $random(seed);
        nextCycle();
        instr = MFLO;
        nextCycle();

        testName = "stallflush";
        repeat (200) begin
            randomFields(32);
            instr = instrT'(pick(35));
            stall = (pick(4) == 0);
            flush = (pick(6) == 0);
            nextCycle();
        end
        stall = 1'b0;
        flush = 1'b0;

        testName = "resettnew";
        reset = 1'b1;
        nextCycle();
        reset = 1'b0;
        for (int t = 0; t < 4; t++) begin
            tnew = tnewT'(t);
            nextCycle();
        end
        instr = NOP;
        nextCycle();
        @(negedge clk);
        #1;
        reported = 1'b1;
        $display("Test completed successfully");
        $finish;
    end

    // Covers runs stopped by a failing bound assertion
    final begin
        if (!reported) begin
            $display("Test failed");
        end
    end

endmodule

// ==== all.f ====
src/execPkg.sv
src/execCtrlIf.sv
src/instrDecoder.sv
src/operandForward.sv
src/aluUnit.sv
src/mulDivUnit.sv
src/executeStage.sv
dv/executeStage_properties.sv
dv/executeStage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module executeStage_tb -f all.f -o simExec

# A fatal check ends the simulator with a nonzero status, the log decides
./obj_dir/simExec 2>&1 | tee sim.log || true

if grep -q "Test failed" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
